//--- dv/gat_stimulus.txt
// Words 0-39: W column by column (word c*8+r = W[c][r]), then a[0..7], one byte each
// Then one line per node: h[0..7], Wh[0..3], src score, dst score (32-bit two's complement)
01 02 03 04 05 06 07 08
ff 01 ff 01 ff 01 ff 01
02 00 fd 00 04 00 fb 00
7f 80 00 00 00 00 00 01
01 fe 03 01 02 01 ff fd
01 01 01 01 01 01 01 01 00000024 00000000 fffffffe 00000000 0000001e 0000004a
02 ff 00 03 fe 01 04 fd 0000000c fffffffc ffffffe8 0000017b 00000147 fffffbbb
80 7f 80 7f 80 7f 80 7f 000001ec 000003fc 00000100 ffff817f ffff7e73 00018257
05 00 f9 03 00 00 02 ff 00000002 00000002 00000015 0000027a 000002b7 fffff883
0a 14 1e 28 f6 ec e2 d8 fffffe70 00000000 00000028 ffffface fffff9b6 00000c4e
03 01 04 01 05 09 02 06 000000a2 00000003 00000004 00000103 000001ab fffffe3a

//--- flist.f
source/gat_pkg.sv
source/weight_bram.sv
source/weight_scheduler.sv
source/feature_fifo.sv
source/wh_engine.sv
source/attn_score.sv
source/gat_layer_top.sv
dv/tb_clock.sv
dv/gat_layer_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run the testbench, then judge the run from its log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module gat_layer_tb \
  -f flist.f -o gat_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/gat_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "Some tests failed" sim.log && exit 1 || exit 0

//--- dv/gat_layer_tb.sv
// Testbench for gat_layer_top with stimulus and expected values from dv/gat_stimulus.txt
// Weights load while the first features are already sent under credits
// Output credits return at random
// Features go out with random idle gaps
`timescale 1ns/10ps

module gat_layer_tb;

  localparam int F_IN        = gat_pkg::F_IN_DEFAULT;
  localparam int F_OUT       = gat_pkg::F_OUT_DEFAULT;
  localparam int FIFO_DEPTH  = 4;
  localparam int OUT_CREDITS = 2;
  localparam int NUM_NODES   = 6;
  localparam int REC_WORDS   = F_IN + F_OUT + 2;
  localparam int STIM_WORDS  = gat_pkg::WEIGHT_WORDS + NUM_NODES * REC_WORDS;
  localparam int READY_DELAY = gat_pkg::WEIGHT_WORDS + 3;
  localparam int CYCLE_LIMIT = 4 * (gat_pkg::WEIGHT_WORDS + NUM_NODES * F_IN) + 200;

  logic                     clk;
  logic                     rst_n;
  logic                     wgt_wr_en;
  gat_pkg::weight_addr_t    wgt_wr_addr;
  gat_pkg::data_t           wgt_wr_data;
  logic                     wgt_load_done;
  logic                     weights_ready;
  logic                     feat_vld;
  gat_pkg::data_t           feat_data;
  logic                     feat_credit;
  logic                     out_vld;
  gat_pkg::wh_t [F_OUT-1:0] out_wh;
  gat_pkg::score_t          out_src_score;
  gat_pkg::score_t          out_dst_score;
  logic                     out_credit;

  logic [31:0] stim [STIM_WORDS];
  logic [31:0] lfsr_state;
  int          exp_q [$];
  int          value_errors;
  int          protocol_errors;
  int          cycle;
  int          load_seen_cycle;
  int          wgt_idx;
  int          feat_sent;
  int          credit_pulses;
  int          send_credits;
  int          dut_credits;
  int          held_results;
  int          results_seen;
  logic        timed_out;

  tb_clock u_clock (
    .clk   (clk),
    .rst_n (rst_n)
  );

  gat_layer_top #(
    .NUM_FEATURE_IN  (F_IN),
    .NUM_FEATURE_OUT (F_OUT),
    .FEAT_FIFO_DEPTH (FIFO_DEPTH),
    .OUT_CREDITS     (OUT_CREDITS)
  ) uut (
    .clk           (clk),
    .rst_n         (rst_n),
    .wgt_wr_en     (wgt_wr_en),
    .wgt_wr_addr   (wgt_wr_addr),
    .wgt_wr_data   (wgt_wr_data),
    .wgt_load_done (wgt_load_done),
    .weights_ready (weights_ready),
    .feat_vld      (feat_vld),
    .feat_data     (feat_data),
    .feat_credit   (feat_credit),
    .out_vld       (out_vld),
    .out_wh        (out_wh),
    .out_src_score (out_src_score),
    .out_dst_score (out_dst_score),
    .out_credit    (out_credit)
  );

  // ====================
  // Random bits
  // ====================
  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic draw_bit(output logic b);
    lfsr_state = lfsr_step(lfsr_state);
    b = lfsr_state[0];
  endtask

  // ====================
  // Checks
  // ====================
  task automatic check_idle_outputs();
    assert (!out_vld) else begin
      $display("** Error out_vld after reset: got %h expected 0", out_vld);
      value_errors++;
    end
    assert (!feat_credit) else begin
      $display("** Error feat_credit after reset: got %h expected 0", feat_credit);
      value_errors++;
    end
    assert (!weights_ready) else begin
      $display("** Error weights_ready after reset: got %h expected 0", weights_ready);
      value_errors++;
    end
  endtask

  task automatic compare_result(input int node);
    int              base;
    gat_pkg::wh_t    exp_wh;
    gat_pkg::score_t exp_src;
    gat_pkg::score_t exp_dst;
    base    = gat_pkg::WEIGHT_WORDS + node * REC_WORDS + F_IN;
    exp_src = gat_pkg::score_t'(stim[base + F_OUT]);
    exp_dst = gat_pkg::score_t'(stim[base + F_OUT + 1]);
    for (int c = 0; c < F_OUT; c++) begin
      exp_wh = gat_pkg::wh_t'(stim[base + c]);
      assert (out_wh[c] == exp_wh) else begin
        $display("** Error node %0d out_wh[%0d]: got %h expected %h", node, c, out_wh[c], exp_wh);
        value_errors++;
      end
    end
    assert (out_src_score == exp_src) else begin
      $display("** Error node %0d out_src_score: got %h expected %h",
               node, out_src_score, exp_src);
      value_errors++;
    end
    assert (out_dst_score == exp_dst) else begin
      $display("** Error node %0d out_dst_score: got %h expected %h",
               node, out_dst_score, exp_dst);
      value_errors++;
    end
  endtask

  // Values seen here are the ones the DUT held up to this edge
  task automatic observe_outputs();
    logic exp_ready;
    int   node;
    if (feat_credit) begin
      credit_pulses++;
      send_credits++;
    end
    assert (credit_pulses <= feat_sent) else begin
      $display("Error: %0d feature credits returned for %0d elements sent", credit_pulses,
               feat_sent);
      protocol_errors++;
    end
    if (wgt_load_done) begin
      load_seen_cycle = cycle;
    end
    exp_ready = (load_seen_cycle >= 0) && (cycle - load_seen_cycle >= READY_DELAY);
    assert (weights_ready == exp_ready) else begin
      $display("** Error weights_ready: got %h expected %h", weights_ready, exp_ready);
      value_errors++;
    end
    if (out_vld) begin
      assert (dut_credits > 0) else begin
        $display("Error: out_vld while the DUT holds no output credit");
        protocol_errors++;
      end
      assert (exp_q.size() > 0) else begin
        $display("Error: out_vld with no complete node outstanding");
        protocol_errors++;
      end
      if (exp_q.size() > 0) begin
        node = exp_q.pop_front();
        compare_result(node);
      end
      results_seen++;
      held_results++;
    end
    dut_credits = dut_credits - int'(out_vld) + int'(out_credit);
  endtask

  // ====================
  // Stimulus
  // ====================
  task automatic drive_weights();
    if (wgt_idx < gat_pkg::WEIGHT_WORDS) begin
      wgt_wr_en   <= 1'b1;
      wgt_wr_addr <= gat_pkg::weight_addr_t'(wgt_idx);
      wgt_wr_data <= gat_pkg::data_t'(stim[wgt_idx]);
      wgt_idx++;
    end else if (wgt_idx == gat_pkg::WEIGHT_WORDS) begin
      wgt_wr_en     <= 1'b0;
      wgt_load_done <= 1'b1;
      wgt_idx++;
    end else begin
      wgt_load_done <= 1'b0;
    end
  endtask

  task automatic drive_features();
    logic b0;
    logic b1;
    int   node;
    int   elem;
    draw_bit(b0);
    draw_bit(b1);
    // Idle in about one cycle of four
    if (feat_sent < NUM_NODES * F_IN && send_credits > 0 && (b0 || b1)) begin
      node = feat_sent / F_IN;
      elem = feat_sent % F_IN;
      feat_vld  <= 1'b1;
      feat_data <= gat_pkg::data_t'(stim[gat_pkg::WEIGHT_WORDS + node * REC_WORDS + elem]);
      send_credits--;
      feat_sent++;
      if (elem == F_IN - 1) begin
        exp_q.push_back(node);
      end
    end else begin
      feat_vld <= 1'b0;
    end
  endtask

  task automatic return_credits();
    logic b;
    draw_bit(b);
    if (held_results > 0 && b) begin
      out_credit <= 1'b1;
      held_results--;
    end else begin
      out_credit <= 1'b0;
    end
  endtask

  // ====================
  // Main sequence
  // ====================
  initial begin
    wgt_wr_en       = 1'b0;
    wgt_wr_addr     = '0;
    wgt_wr_data     = '0;
    wgt_load_done   = 1'b0;
    feat_vld        = 1'b0;
    feat_data       = '0;
    out_credit      = 1'b0;
    lfsr_state      = 32'he4f5;
    value_errors    = 0;
    protocol_errors = 0;
    cycle           = 0;
    load_seen_cycle = -1;
    wgt_idx         = 0;
    feat_sent       = 0;
    credit_pulses   = 0;
    send_credits    = FIFO_DEPTH;
    dut_credits     = OUT_CREDITS;
    held_results    = 0;
    results_seen    = 0;
    timed_out       = 1'b0;
    $readmemh("dv/gat_stimulus.txt", stim);

    @(posedge rst_n);
    repeat (3) begin
      @(posedge clk);
      check_idle_outputs();
    end

    while (!(results_seen == NUM_NODES && credit_pulses == NUM_NODES * F_IN) &&
           cycle < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle++;
      observe_outputs();
      drive_weights();
      drive_features();
      return_credits();
    end

    if (results_seen != NUM_NODES || credit_pulses != NUM_NODES * F_IN) begin
      timed_out = 1'b1;
      $display("Timeout: stopped after %0d cycles with %0d of %0d results received",
               cycle, results_seen, NUM_NODES);
    end
    assert (credit_pulses == feat_sent) else begin
      $display("Error: %0d feature credits returned for %0d elements sent at end of run",
               credit_pulses, feat_sent);
      protocol_errors++;
    end

    $display("Summary: %0d value errors, %0d protocol errors, %0d timeouts",
             value_errors, protocol_errors, int'(timed_out));
    if (value_errors == 0 && protocol_errors == 0 && !timed_out) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- dv/tb_clock.sv
// Clock and reset source for the testbench
// 4 ns period, rst_n held low for the first two rising edges
`timescale 1ns/10ps

module tb_clock #(
  parameter int HALF_PERIOD  = 2,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

//--- source/gat_layer_top.sv
// Layer-2 attention fragment: weight load, Wh transform and attention halves
// Feature sizes must stay at the package defaults, the BRAM layout uses them
// Weights load once per reset
`timescale 1ns/10ps

module gat_layer_top #(
  parameter int NUM_FEATURE_IN  = gat_pkg::F_IN_DEFAULT,
  parameter int NUM_FEATURE_OUT = gat_pkg::F_OUT_DEFAULT,
  parameter int FEAT_FIFO_DEPTH = 4,
  parameter int OUT_CREDITS     = 2
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               wgt_wr_en,
  input  gat_pkg::weight_addr_t              wgt_wr_addr,
  input  gat_pkg::data_t                     wgt_wr_data,
  input  logic                               wgt_load_done,
  output logic                               weights_ready,
  input  logic                               feat_vld,
  input  gat_pkg::data_t                     feat_data,
  output logic                               feat_credit,
  output logic                               out_vld,
  output gat_pkg::wh_t [NUM_FEATURE_OUT-1:0] out_wh,
  output gat_pkg::score_t                    out_src_score,
  output gat_pkg::score_t                    out_dst_score,
  input  logic                               out_credit
);

  gat_pkg::weight_addr_t                                    wgt_rd_addr;
  gat_pkg::data_t                                           wgt_rd_data;
  gat_pkg::data_t [NUM_FEATURE_OUT-1:0][NUM_FEATURE_IN-1:0] wgt_matrix;
  gat_pkg::data_t [2*NUM_FEATURE_OUT-1:0]                   attn_vec;
  logic                                                     fifo_rd_en;
  logic                                                     fifo_not_empty;
  gat_pkg::data_t                                           fifo_data;
  logic                                                     wh_vld;
  gat_pkg::wh_t [NUM_FEATURE_OUT-1:0]                       wh_vec;
  logic                                                     wh_accept;

  // ====================
  // Weight path
  // ====================
  weight_bram u_weight_bram (
    .clk     (clk),
    .wr_en   (wgt_wr_en),
    .wr_addr (wgt_wr_addr),
    .wr_data (wgt_wr_data),
    .rd_addr (wgt_rd_addr),
    .rd_data (wgt_rd_data)
  );

  weight_scheduler #(
    .NUM_FEATURE_IN  (NUM_FEATURE_IN),
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT)
  ) u_weight_scheduler (
    .clk           (clk),
    .rst_n         (rst_n),
    .load_done     (wgt_load_done),
    .rd_addr       (wgt_rd_addr),
    .rd_data       (wgt_rd_data),
    .wgt_matrix    (wgt_matrix),
    .attn_vec      (attn_vec),
    .weights_ready (weights_ready)
  );

  // ====================
  // Feature datapath
  // ====================
  feature_fifo #(
    .FEAT_FIFO_DEPTH (FEAT_FIFO_DEPTH)
  ) u_feature_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_vld    (feat_vld),
    .wr_data   (feat_data),
    .rd_en     (fifo_rd_en),
    .rd_data   (fifo_data),
    .not_empty (fifo_not_empty),
    .credit    (feat_credit)
  );

  wh_engine #(
    .NUM_FEATURE_IN  (NUM_FEATURE_IN),
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT)
  ) u_wh_engine (
    .clk            (clk),
    .rst_n          (rst_n),
    .weights_ready  (weights_ready),
    .wgt_matrix     (wgt_matrix),
    .fifo_not_empty (fifo_not_empty),
    .fifo_data      (fifo_data),
    .fifo_rd_en     (fifo_rd_en),
    .wh_vld         (wh_vld),
    .wh_vec         (wh_vec),
    .wh_accept      (wh_accept)
  );

  attn_score #(
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT),
    .OUT_CREDITS     (OUT_CREDITS)
  ) u_attn_score (
    .clk           (clk),
    .rst_n         (rst_n),
    .attn_vec      (attn_vec),
    .wh_vld        (wh_vld),
    .wh_vec        (wh_vec),
    .wh_accept     (wh_accept),
    .out_vld       (out_vld),
    .out_wh        (out_wh),
    .out_src_score (out_src_score),
    .out_dst_score (out_dst_score),
    .out_credit    (out_credit)
  );

endmodule

//--- source/attn_score.sv
// Source and destination halves of the attention logit for one node
// Results leave only against credits returned by the consumer
// One-entry result register, no new vector while it is occupied
`timescale 1ns/10ps

module attn_score #(
  parameter int NUM_FEATURE_OUT = gat_pkg::F_OUT_DEFAULT,
  parameter int OUT_CREDITS     = 2
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  gat_pkg::data_t [2*NUM_FEATURE_OUT-1:0] attn_vec,
  input  logic                                   wh_vld,
  input  gat_pkg::wh_t [NUM_FEATURE_OUT-1:0]     wh_vec,
  output logic                                   wh_accept,
  output logic                                   out_vld,
  output gat_pkg::wh_t [NUM_FEATURE_OUT-1:0]     out_wh,
  output gat_pkg::score_t                        out_src_score,
  output gat_pkg::score_t                        out_dst_score,
  input  logic                                   out_credit
);

  localparam int CRD_W = $clog2(OUT_CREDITS + 1);

  logic [CRD_W-1:0] credit_cnt;
  logic             res_full;
  gat_pkg::score_t  src_sum;
  gat_pkg::score_t  dst_sum;

  assign wh_accept = wh_vld && !res_full;
  assign out_vld   = res_full && (credit_cnt != '0);

  // First half of a against Wh, second half of a against Wh
  always_comb begin
    src_sum = '0;
    dst_sum = '0;
    for (int c = 0; c < NUM_FEATURE_OUT; c++) begin
      src_sum = src_sum + $signed(attn_vec[c]) * $signed(wh_vec[c]);
      dst_sum = dst_sum + $signed(attn_vec[NUM_FEATURE_OUT + c]) * $signed(wh_vec[c]);
    end
  end

  // ====================
  // Result and credits
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_full   <= 1'b0;
      credit_cnt <= CRD_W'(OUT_CREDITS);
    end else begin
      if (wh_accept) begin
        res_full <= 1'b1;
      end else if (out_vld) begin
        res_full <= 1'b0;
      end
      if (out_credit && !out_vld) begin
        credit_cnt <= credit_cnt + 1'b1;
      end else if (out_vld && !out_credit) begin
        credit_cnt <= credit_cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wh_accept) begin
      out_wh        <= wh_vec;
      out_src_score <= src_sum;
      out_dst_score <= dst_sum;
    end
  end

endmodule

//--- source/wh_engine.sv
// Computes Wh one input feature per cycle, F_OUT dot products in parallel
// Node boundaries are implicit, every NUM_FEATURE_IN elements
// Waits for weights_ready before the first pop
`timescale 1ns/10ps

module wh_engine #(
  parameter int NUM_FEATURE_IN  = gat_pkg::F_IN_DEFAULT,
  parameter int NUM_FEATURE_OUT = gat_pkg::F_OUT_DEFAULT
) (
  input  logic                                                     clk,
  input  logic                                                     rst_n,
  input  logic                                                     weights_ready,
  input  gat_pkg::data_t [NUM_FEATURE_OUT-1:0][NUM_FEATURE_IN-1:0] wgt_matrix,
  input  logic                                                     fifo_not_empty,
  input  gat_pkg::data_t                                           fifo_data,
  output logic                                                     fifo_rd_en,
  output logic                                                     wh_vld,
  output gat_pkg::wh_t [NUM_FEATURE_OUT-1:0]                       wh_vec,
  input  logic                                                     wh_accept
);

  localparam int               IDX_W    = (NUM_FEATURE_IN > 1) ? $clog2(NUM_FEATURE_IN) : 1;
  localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(NUM_FEATURE_IN - 1);

  logic [IDX_W-1:0]                   feat_idx;
  logic                               last_elem;
  gat_pkg::wh_t [NUM_FEATURE_OUT-1:0] acc;
  gat_pkg::wh_t [NUM_FEATURE_OUT-1:0] sum_next;

  // Stall while a finished vector still waits for attn_score
  assign fifo_rd_en = weights_ready && fifo_not_empty && (!wh_vld || wh_accept);
  assign last_elem  = (feat_idx == IDX_LAST);

  // ====================
  // Multiply-accumulate
  // ====================
  always_comb begin
    for (int c = 0; c < NUM_FEATURE_OUT; c++) begin
      // h[r] * W[c][r], sign extended to the accumulator width
      sum_next[c] = acc[c] + $signed(fifo_data) * $signed(wgt_matrix[c][feat_idx]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      feat_idx <= '0;
      acc      <= '0;
      wh_vld   <= 1'b0;
    end else begin
      if (fifo_rd_en) begin
        if (last_elem) begin
          // Clear for the next node
          feat_idx <= '0;
          acc      <= '0;
        end else begin
          feat_idx <= feat_idx + 1'b1;
          acc      <= sum_next;
        end
      end
      // A new vector takes over in the cycle the old one is accepted
      if (fifo_rd_en && last_elem) begin
        wh_vld <= 1'b1;
      end else if (wh_accept) begin
        wh_vld <= 1'b0;
      end
    end
  end

  // Output holding register
  always_ff @(posedge clk) begin
    if (fifo_rd_en && last_elem) begin
      wh_vec <= sum_next;
    end
  end

endmodule

//--- source/feature_fifo.sv
// Node feature FIFO with show-ahead read data
// One credit pulse leaves the cycle after each element is released
// The sender must start with FEAT_FIFO_DEPTH credits and never exceed them
`timescale 1ns/10ps

module feature_fifo #(
  parameter int FEAT_FIFO_DEPTH = 4
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           wr_vld,
  input  gat_pkg::data_t wr_data,
  input  logic           rd_en,
  output gat_pkg::data_t rd_data,
  output logic           not_empty,
  output logic           credit
);

  localparam int PTR_W = (FEAT_FIFO_DEPTH > 1) ? $clog2(FEAT_FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FEAT_FIFO_DEPTH + 1);

  gat_pkg::data_t   mem [FEAT_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // Circular pointer step for depths that are not a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(FEAT_FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign not_empty = (count != '0);
  assign pop       = rd_en && not_empty;
  // A full FIFO takes a new element only when one leaves in the same cycle
  assign push      = wr_vld && ((count != CNT_W'(FEAT_FIFO_DEPTH)) || pop);
  assign rd_data   = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      credit <= pop;
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

//--- source/weight_scheduler.sv
// Fetches W and a from the weight BRAM once after load_done
// Assumes the BRAM read latency is exactly two cycles
// A second load needs a reset, later load_done pulses are ignored
`timescale 1ns/10ps

module weight_scheduler #(
  parameter int NUM_FEATURE_IN  = gat_pkg::F_IN_DEFAULT,
  parameter int NUM_FEATURE_OUT = gat_pkg::F_OUT_DEFAULT
) (
  input  logic                                                     clk,
  input  logic                                                     rst_n,
  input  logic                                                     load_done,
  output gat_pkg::weight_addr_t                                    rd_addr,
  input  gat_pkg::data_t                                           rd_data,
  output gat_pkg::data_t [NUM_FEATURE_OUT-1:0][NUM_FEATURE_IN-1:0] wgt_matrix,
  output gat_pkg::data_t [2*NUM_FEATURE_OUT-1:0]                   attn_vec,
  output logic                                                     weights_ready
);

  localparam int NUM_WORDS = NUM_FEATURE_OUT * NUM_FEATURE_IN + 2 * NUM_FEATURE_OUT;
  localparam int ROW_W     = (NUM_FEATURE_IN > 1) ? $clog2(NUM_FEATURE_IN) : 1;
  localparam int COL_W     = (NUM_FEATURE_OUT > 1) ? $clog2(NUM_FEATURE_OUT) : 1;
  localparam int ATTN_W    = $clog2(2 * NUM_FEATURE_OUT);

  localparam gat_pkg::weight_addr_t ADDR_LAST = gat_pkg::weight_addr_t'(NUM_WORDS - 1);
  localparam logic [ROW_W-1:0]      ROW_LAST  = ROW_W'(NUM_FEATURE_IN - 1);
  localparam logic [COL_W-1:0]      COL_LAST  = COL_W'(NUM_FEATURE_OUT - 1);
  localparam logic [ATTN_W-1:0]     ATTN_LAST = ATTN_W'(2 * NUM_FEATURE_OUT - 1);

  logic              fetching;
  logic              vld_q1;
  logic              vld_q2;
  logic              matrix_done;
  logic [ROW_W-1:0]  row_idx;
  logic [COL_W-1:0]  col_idx;
  logic [ATTN_W-1:0] attn_idx;

  // ====================
  // Address sequencer
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetching <= 1'b0;
      rd_addr  <= '0;
    end else if (!fetching) begin
      // Address still at zero means no fetch has run yet
      if (load_done && rd_addr == '0) begin
        fetching <= 1'b1;
      end
    end else if (rd_addr == ADDR_LAST) begin
      fetching <= 1'b0;
    end else begin
      rd_addr <= rd_addr + 1'b1;
    end
  end

  // Valid follows the address through the two BRAM stages
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q1 <= 1'b0;
      vld_q2 <= 1'b0;
    end else begin
      vld_q1 <= fetching;
      vld_q2 <= vld_q1;
    end
  end

  // ====================
  // Unpack returning words
  // ====================
  // Row index is the inner counter since W is stored column after column
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      row_idx       <= '0;
      col_idx       <= '0;
      matrix_done   <= 1'b0;
      attn_idx      <= '0;
      weights_ready <= 1'b0;
    end else if (vld_q2) begin
      if (!matrix_done) begin
        if (row_idx == ROW_LAST) begin
          row_idx <= '0;
          if (col_idx == COL_LAST) begin
            matrix_done <= 1'b1;
          end else begin
            col_idx <= col_idx + 1'b1;
          end
        end else begin
          row_idx <= row_idx + 1'b1;
        end
      end else if (!weights_ready) begin
        attn_idx <= attn_idx + 1'b1;
        if (attn_idx == ATTN_LAST) begin
          weights_ready <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (vld_q2 && !matrix_done) begin
      wgt_matrix[col_idx][row_idx] <= rd_data;
    end
    if (vld_q2 && matrix_done && !weights_ready) begin
      attn_vec[attn_idx] <= rd_data;
    end
  end

endmodule

//--- source/weight_bram.sv
// Simple dual-port weight memory, one write port and one read port
// Read data appears two cycles after the read address
// Addresses at or above WEIGHT_WORDS are not backed by storage
`timescale 1ns/10ps

module weight_bram (
  input  logic                  clk,
  input  logic                  wr_en,
  input  gat_pkg::weight_addr_t wr_addr,
  input  gat_pkg::data_t        wr_data,
  input  gat_pkg::weight_addr_t rd_addr,
  output gat_pkg::data_t        rd_data
);

  gat_pkg::data_t        mem [gat_pkg::WEIGHT_WORDS];
  gat_pkg::weight_addr_t rd_addr_q;

  // Write port from the external loader
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered address, then registered data
  always_ff @(posedge clk) begin
    rd_addr_q <= rd_addr;
    rd_data   <= mem[rd_addr_q];
  end

endmodule

//--- source/gat_pkg.sv
// Shared types and weight memory layout for the layer-2 attention fragment
// Layout constants are derived from the default feature sizes only
// Sums are kept full width, no fixed-point rescaling anywhere
package gat_pkg;

  // ====================
  // Feature sizes
  // ====================
  localparam int F_IN_DEFAULT  = 8;
  localparam int F_OUT_DEFAULT = 4;

  // W column by column, then a[0..2F-1]
  localparam int WEIGHT_WORDS  = F_OUT_DEFAULT * F_IN_DEFAULT + 2 * F_OUT_DEFAULT;
  localparam int WEIGHT_ADDR_W = $clog2(WEIGHT_WORDS);

  // ====================
  // Data types
  // ====================
  // Feature, weight or attention weight
  typedef logic signed [7:0] data_t;

  // 16-bit product plus 3 bits of growth over 8 terms
  typedef logic signed [18:0] wh_t;

  // Four 27-bit products plus growth
  typedef logic signed [31:0] score_t;

  // Weight BRAM address
  typedef logic [WEIGHT_ADDR_W-1:0] weight_addr_t;

endpackage
